// ==== hdl/coupler_defines.svh ====
`ifndef COUPLER_DEFINES_SVH
`define COUPLER_DEFINES_SVH

// narrow word width, the output side is exactly twice this
`define CPL_WIDTH 32

// entries per FIFO, both sides
`define CPL_FIFO_DEPTH 16

// pointer width, must match log2 of the depth
`define CPL_FIFO_AW 4

`endif

// ==== hdl/coupler_pkg.sv ====
`default_nettype none

`include "coupler_defines.svh"

package coupler_pkg;

   // one narrow word as it arrives on i_data
   typedef logic [`CPL_WIDTH-1:0] word_t;

   // lo holds the earlier word, so it sits in the low half
   typedef struct packed {
      word_t hi;
      word_t lo;
   } pair_t;

   // packer position within the current pair
   typedef enum logic [0:0] {
      ST_LOW  = 1'b0,   // waiting for the low word
      ST_HIGH = 1'b1    // lo captured, waiting for the high word
   } pack_state_t;

endpackage

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "coupler_defines.svh"

module sync_fifo #(
   parameter int WIDTH = `CPL_WIDTH
) (
   input  wire logic             i_clk,
   input  wire logic             i_reset,
   input  wire logic [WIDTH-1:0] i_data,
   input  wire logic             i_enq,
   input  wire logic             i_deq,
   output logic      [WIDTH-1:0] o_data,
   output logic                  o_full,
   output logic                  o_empty
);

   localparam logic [`CPL_FIFO_AW:0] DEPTH_CNT = `CPL_FIFO_DEPTH;

   logic [WIDTH-1:0]        mem [`CPL_FIFO_DEPTH];
   logic [`CPL_FIFO_AW-1:0] wr_ptr;
   logic [`CPL_FIFO_AW-1:0] rd_ptr;
   logic [`CPL_FIFO_AW:0]   count;
   logic [`CPL_FIFO_AW:0]   count_nxt;
   logic                    full_q;
   logic                    empty_q;
   logic                    wr_en;
   logic                    rd_en;

   // strobes against the wrong level are dropped here
   assign wr_en = i_enq & ~full_q;
   assign rd_en = i_deq & ~empty_q;

   always_comb begin
      count_nxt = count;
      case ({wr_en, rd_en})
         2'b10:   count_nxt = count + 1'b1;
         2'b01:   count_nxt = count - 1'b1;
         default: count_nxt = count;   // idle or enq+deq together
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         full_q  <= 1'b0;
         empty_q <= 1'b1;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count   <= count_nxt;
         full_q  <= (count_nxt == DEPTH_CNT);
         empty_q <= (count_nxt == '0);
      end
   end

   // storage itself is not cleared
   always_ff @(posedge i_clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // fall-through head
   assign o_data  = mem[rd_ptr];
   assign o_full  = full_q;
   assign o_empty = empty_q;

endmodule

`default_nettype wire

// ==== hdl/pair_packer.sv ====
`timescale 1ns/1ns
`default_nettype none

module pair_packer
   import coupler_pkg::*;
(
   input  wire logic  i_clk,
   input  wire logic  i_reset,
   input  wire word_t i_in_word,
   input  wire logic  i_in_empty,
   output logic       o_in_deq,
   input  wire logic  i_out_full,
   output logic       o_out_enq,
   output pair_t      o_out_pair
);

   pack_state_t state;
   pack_state_t state_nxt;
   word_t       lo_q;
   word_t       lo_nxt;
   logic        step;      // both sides ready this cycle
   logic        lo_zero;

   // nothing moves unless there is a word to read and room to write
   assign step    = ~i_in_empty & ~i_out_full;
   assign lo_zero = (lo_q == '0);

   always_comb begin
      state_nxt = state;
      lo_nxt    = lo_q;
      o_in_deq  = 1'b0;
      o_out_enq = 1'b0;

      // lo always comes from the held word
      o_out_pair.lo = lo_q;
      o_out_pair.hi = i_in_word;

      case (state)
         ST_LOW: begin
            if (step) begin
               o_in_deq  = 1'b1;
               lo_nxt    = i_in_word;
               state_nxt = ST_HIGH;
            end
         end

         ST_HIGH: begin
            if (lo_zero) begin
               // zero low word closes the pair early
               o_out_pair.hi = '0;
            end
            if (step) begin
               o_out_enq = 1'b1;
               // head stays put after an early close, it becomes the next lo
               o_in_deq  = ~lo_zero;
               state_nxt = ST_LOW;
            end
         end

         default: begin
            state_nxt = ST_LOW;
         end
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state <= ST_LOW;
      end else begin
         state <= state_nxt;
      end
   end

   // payload only, valid whenever state is ST_HIGH
   always_ff @(posedge i_clk) begin
      lo_q <= lo_nxt;
   end

endmodule

`default_nettype wire

// ==== hdl/word_coupler.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "coupler_defines.svh"

module word_coupler
   import coupler_pkg::*;
(
   input  wire logic  i_clk,
   input  wire logic  i_reset,
   input  wire word_t i_data,
   input  wire logic  i_enq,
   output logic       o_full,
   input  wire logic  i_deq,
   output pair_t      o_data,
   output logic       o_empty
);

   word_t in_word;    // input FIFO head
   logic  in_empty;
   logic  in_deq;
   pair_t out_pair;
   logic  out_enq;
   logic  out_full;

   // narrow side
   sync_fifo #(
      .WIDTH (`CPL_WIDTH)
   ) in_fifo (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_data  (i_data),
      .i_enq   (i_enq),
      .i_deq   (in_deq),
      .o_data  (in_word),
      .o_full  (o_full),
      .o_empty (in_empty)
   );

   pair_packer packer (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .i_in_word  (in_word),
      .i_in_empty (in_empty),
      .o_in_deq   (in_deq),
      .i_out_full (out_full),
      .o_out_enq  (out_enq),
      .o_out_pair (out_pair)
   );

   // double width side, hi in the upper half
   sync_fifo #(
      .WIDTH (2 * `CPL_WIDTH)
   ) out_fifo (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_data  (out_pair),
      .i_enq   (out_enq),
      .i_deq   (i_deq),
      .o_data  (o_data),
      .o_full  (out_full),
      .o_empty (o_empty)
   );

endmodule

`default_nettype wire

// ==== tb/word_coupler_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module word_coupler_props
   import coupler_pkg::*;
(
   input wire logic        i_clk,
   input wire logic        i_reset,
   input wire logic        i_in_empty,
   input wire logic        i_in_deq,
   input wire logic        i_out_full,
   input wire logic        i_out_enq,
   input wire pack_state_t i_state,
   input wire word_t       i_lo
);

   logic stalled;

   assign stalled = i_in_empty | i_out_full;

   deq_needs_word: assert property (@(posedge i_clk) disable iff (i_reset)
      !(i_in_deq && i_in_empty))
      else $error("packer dequeued from an empty input FIFO");

   enq_needs_room: assert property (@(posedge i_clk) disable iff (i_reset)
      !(i_out_enq && i_out_full))
      else $error("packer enqueued into a full output FIFO");

   // early close: pair goes out, head word stays for the next lo
   zero_lo_close: assert property (@(posedge i_clk) disable iff (i_reset)
      (i_state == ST_HIGH && i_lo == '0 && !stalled) |-> (i_out_enq && !i_in_deq))
      else $error("zero low word did not close its pair without a dequeue");

   stall_holds_state: assert property (@(posedge i_clk) disable iff (i_reset)
      stalled |=> $stable(i_state))
      else $error("packer state moved while stalled");

endmodule

bind pair_packer word_coupler_props packer_props (
   .i_clk      (i_clk),
   .i_reset    (i_reset),
   .i_in_empty (i_in_empty),
   .i_in_deq   (o_in_deq),
   .i_out_full (i_out_full),
   .i_out_enq  (o_out_enq),
   .i_state    (state),
   .i_lo       (lo_q)
);

`default_nettype wire

// ==== tb/word_coupler_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "coupler_defines.svh"

module word_coupler_tb
   import coupler_pkg::*;
();

   localparam int unsigned SEED = 32'h0ce7_0dce;
   localparam int N_EVEN = 20;
   localparam int N_ZERO = 11;
   localparam int N_BP   = 4 * `CPL_FIFO_DEPTH;   // well past what the DUT can hold
   localparam int RAND_LEN [4] = '{49, 51, 37, 63};
   localparam int N_RAND = 200;                    // sum of RAND_LEN
   localparam int TOTAL_WORDS = N_EVEN + N_ZERO + N_BP + N_RAND;
   localparam int TIMEOUT_CYCLES = 20 * TOTAL_WORDS + 200;

   logic  i_clk   = 1'b0;
   logic  i_reset = 1'b1;
   word_t i_data  = '0;
   logic  i_enq   = 1'b0;
   logic  i_deq   = 1'b0;
   pair_t o_data;
   logic  o_full;
   logic  o_empty;

   pair_t exp_q[$];
   pair_t exp_pair;
   logic  carry_valid = 1'b0;   // unpaired word still inside the DUT
   word_t carry_word  = '0;
   int    deq_mode    = 0;      // 0 hold low, 1 always, 2 random
   string test_name   = "none";
   int    test_errs   = 0;
   int    tests_passed = 0;
   int    tests_failed = 0;
   logic  saw_full    = 1'b0;

   word_coupler i_dut (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_data  (i_data),
      .i_enq   (i_enq),
      .o_full  (o_full),
      .i_deq   (i_deq),
      .o_data  (o_data),
      .o_empty (o_empty)
   );

   always #2 i_clk = ~i_clk;

   // expected pairs in arrival order with early close on a zero lo
   function automatic void reference_pairs(input word_t words[$]);
      pair_t p;
      foreach (words[i]) begin
         if (!carry_valid) begin
            carry_word  = words[i];
            carry_valid = 1'b1;
         end else if (carry_word == '0) begin
            p.lo = '0;
            p.hi = '0;
            exp_q.push_back(p);
            carry_word = words[i];   // still holding a lo
         end else begin
            p.lo = carry_word;
            p.hi = words[i];
            exp_q.push_back(p);
            carry_valid = 1'b0;
         end
      end
   endfunction

   function automatic word_t rand_word(input int unsigned zero_pct);
      word_t w;
      w = word_t'($urandom);
      if (($urandom % 100) < zero_pct) begin
         w = '0;
      end else if (w == '0) begin
         w = word_t'(1);
      end
      return w;
   endfunction

   always @(posedge i_clk) begin
      if (i_reset) begin
         i_deq <= 1'b0;
      end else begin
         case (deq_mode)
            0:       i_deq <= 1'b0;
            1:       i_deq <= 1'b1;
            default: i_deq <= ($urandom % 2 == 0);
         endcase
      end
   end

   // sampled mid-cycle where everything is settled
   always @(negedge i_clk) begin
      if (!i_reset) begin
         assert (!(i_enq && o_full)) else begin
            $display("enq raised while o_full was high in test %s", test_name);
            test_errs++;
         end
         if (i_deq && !o_empty) begin
            assert (exp_q.size() != 0) else begin
               $display("pair %h came out with none expected in test %s", o_data, test_name);
               test_errs++;
            end
            if (exp_q.size() != 0) begin
               exp_pair = exp_q.pop_front();
               assert (o_data == exp_pair) else begin
                  $display("Fail %s: expected %h actual %h", test_name, exp_pair, o_data);
                  test_errs++;
               end
            end
         end
      end
   end

   // at most one word per two cycles so full is checked with enq low
   task automatic drive_words(input word_t words[$], input bit gaps);
      int unsigned gap;
      foreach (words[i]) begin
         @(negedge i_clk);
         while (o_full) begin
            @(negedge i_clk);
         end
         @(posedge i_clk);
         i_data <= words[i];
         i_enq  <= 1'b1;
         @(posedge i_clk);
         i_enq  <= 1'b0;
         if (gaps) begin
            gap = $urandom % 4;
            repeat (gap) @(posedge i_clk);
         end
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic end_test(input int n_words);
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < 20 * n_words + 100) begin
         @(negedge i_clk);
         waited++;
      end
      assert (exp_q.size() == 0) else begin
         $display("test %s ended with %0d pairs never delivered", test_name, exp_q.size());
         test_errs += exp_q.size();
         exp_q.delete();
      end
      repeat (8) @(negedge i_clk);   // catch stray extra pairs
      if (test_errs == 0) begin
         tests_passed++;
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", test_name, test_errs);
      end
   endtask

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge i_clk);
         cycles++;
      end
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin : main
      word_t words[$];
      void'($urandom(SEED));
      repeat (3) @(posedge i_clk);
      i_reset <= 1'b0;

      start_test("reset_idle");
      deq_mode = 1;
      @(negedge i_clk);
      assert (o_empty && !o_full) else begin
         $display("o_empty or o_full not at reset level after reset");
         test_errs++;
      end
      repeat (10) begin
         @(negedge i_clk);
         assert (o_empty) else begin
            $display("o_empty dropped with nothing enqueued");
            test_errs++;
         end
      end
      end_test(0);

      start_test("even_stream");
      words.delete();
      repeat (N_EVEN) words.push_back(rand_word(0));
      reference_pairs(words);
      drive_words(words, 1'b0);
      end_test(N_EVEN);

      start_test("zero_slots");
      words = '{word_t'(0), word_t'(32'h0000_00a1), word_t'(32'h0000_00b2), word_t'(0),
                word_t'(32'h0000_00c3), word_t'(0), word_t'(0), word_t'(32'h0000_00d4),
                word_t'(0), word_t'(32'h0000_00e5), word_t'(32'h0000_00f6)};
      reference_pairs(words);
      drive_words(words, 1'b0);
      end_test(N_ZERO);

      start_test("back_pressure");
      deq_mode = 0;
      saw_full = 1'b0;
      words.delete();
      repeat (N_BP) words.push_back(rand_word(0));
      reference_pairs(words);
      fork
         drive_words(words, 1'b0);
         begin
            @(negedge i_clk);
            for (int c = 0; c < 4 * N_BP && !o_full; c++) begin
               @(negedge i_clk);
            end
            saw_full = o_full;
            repeat (4) @(negedge i_clk);   // sit full for a bit
            deq_mode = 1;
         end
      join
      assert (saw_full) else begin
         $display("o_full never rose with i_deq held low");
         test_errs++;
      end
      end_test(N_BP);

      deq_mode = 2;
      foreach (RAND_LEN[s]) begin
         start_test($sformatf("random_%0d", s));
         words.delete();
         repeat (RAND_LEN[s]) words.push_back(rand_word(25));
         reference_pairs(words);
         drive_words(words, 1'b1);
         end_test(RAND_LEN[s]);
      end

      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/coupler_pkg.sv
hdl/sync_fifo.sv
hdl/pair_packer.sv
hdl/word_coupler.sv
tb/word_coupler_props.sv
tb/word_coupler_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and exit nonzero unless the testbench passed
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module word_coupler_tb -f project.f \
   -o word_coupler_sim || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/word_coupler_sim)"
echo "$sim_out"

echo "$sim_out" | grep -qx "RESULT: PASS" && exit 0 || exit 1
